//--- hw/board_pkg.sv
`default_nettype none

package board_pkg;

    localparam int CLK_MHZ         = 100;
    localparam int SIO_HALF_CYCLES = 16;  // TM1638 clock half period in clk cycles.
    localparam int SCK_HALF_CYCLES = 16;  // Microphone clock half period in clk cycles.
    localparam int SAMPLE_W        = 24;

    // One microphone word, value is two's complement.
    typedef struct packed {
        logic signed [SAMPLE_W - 1:0] value;
        logic                         valid;  // One-cycle strobe.
    } sample_t;

endpackage

`default_nettype wire

//--- hw/tm1638_pkg.sv
`default_nettype none

package tm1638_pkg;

    localparam int DIGITS    = 8;
    localparam int KEY_BYTES = 4;

    typedef enum logic [7:0] {
        CMD_WRITE_AUTO = 8'h40,  // Write with address auto increment.
        CMD_READ_KEYS  = 8'h42,
        CMD_ADDR0      = 8'hC0,
        CMD_DISPLAY_ON = 8'h8F   // Display on, full brightness.
    } tm_cmd_e;

    typedef enum logic [2:0] {
        ST_SNAP,
        ST_CMD,
        ST_DATA,
        ST_WAIT,
        ST_END
    } tm_state_e;

    // Segment byte per digit, bit 0 is segment a and bit 7 is dp.
    typedef struct packed {
        logic [DIGITS - 1:0][7:0] segments;
        logic [7:0]               leds;
    } panel_frame_t;

    typedef struct packed {
        logic [7:0] data;
        logic       read;
    } shift_req_t;

    typedef logic [7:0] panel_keys_t;

endpackage

`default_nettype wire

//--- hw/serial_clk_timer.sv
`default_nettype none

module serial_clk_timer
#(
    parameter int half_cycles = 16
)
(
    input  logic clk,
    input  logic rst_n,
    input  logic enable,
    output logic level,
    output logic rise,
    output logic fall
);

    typedef logic [$clog2(half_cycles + 1) - 1:0] cnt_t;

    cnt_t cnt;

    // Strobes are registered, so they line up with the new level.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cnt   <= cnt_t'(half_cycles - 1);
            level <= !enable;  // A free-running clock starts low.
            rise  <= 1'b0;
            fall  <= 1'b0;
        end
        else if (!enable)
        begin
            cnt   <= cnt_t'(half_cycles - 1);
            level <= 1'b1;  // Idle level.
            rise  <= 1'b0;
            fall  <= 1'b0;
        end
        else
        begin
            rise <= 1'b0;
            fall <= 1'b0;
            if (cnt == '0)
            begin
                cnt   <= cnt_t'(half_cycles - 1);
                level <= ~level;
                rise  <= ~level;
                fall  <= level;
            end
            else
                cnt <= cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/i2s_mic_receiver.sv
`default_nettype none

module i2s_mic_receiver
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sck_rise,
    input  logic               ws,
    input  logic               sd,
    output board_pkg::sample_t sample
);

    logic                                   ws_q;
    logic [$clog2(board_pkg::SAMPLE_W + 1) - 1:0] bit_cnt;  // Bits still to come.
    logic [board_pkg::SAMPLE_W - 1:0]       shreg;
    logic                                   word_done;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ws_q         <= 1'b0;
            bit_cnt      <= '0;
            word_done    <= 1'b0;
            sample.valid <= 1'b0;
        end
        else
        begin
            word_done    <= 1'b0;
            sample.valid <= word_done;
            if (word_done)
                sample.value <= shreg;

            if (sck_rise)
            begin
                ws_q <= ws;
                // The rise that sees ws low for the first time carries the
                // one-bit delay slot, the MSB follows on the next rise.
                if (ws_q && !ws)
                    bit_cnt <= board_pkg::SAMPLE_W[$bits(bit_cnt) - 1:0];
                else if (bit_cnt != '0)
                begin
                    shreg     <= {shreg[board_pkg::SAMPLE_W - 2:0], sd};  // MSB first.
                    bit_cnt   <= bit_cnt - 1'b1;
                    word_done <= (bit_cnt == 1);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/tm1638_shifter.sv
`default_nettype none

module tm1638_shifter
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  tm1638_pkg::shift_req_t req,
    input  logic                   sio_rise,
    input  logic                   sio_fall,
    output logic                   sio_en,
    output logic                   sio_data_out,
    output logic                   sio_data_oe,
    input  logic                   sio_data_in,
    output logic                   done,
    output logic [7:0]             rd_data
);

    logic       busy;
    logic       rd_mode;
    logic [2:0] bit_cnt;
    logic [7:0] shreg;

    // One register serves both directions.
    // Out of bit 0 on the fall, in at bit 7 on the rise.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy         <= 1'b0;
            rd_mode      <= 1'b0;
            bit_cnt      <= '0;
            done         <= 1'b0;
            sio_data_out <= 1'b1;
        end
        else
        begin
            done <= 1'b0;
            if (start && !busy)
            begin
                busy    <= 1'b1;
                rd_mode <= req.read;
                shreg   <= req.data;
                bit_cnt <= '0;
            end
            else if (busy)
            begin
                if (sio_fall && !rd_mode)
                    sio_data_out <= shreg[0];  // LSB first.
                if (sio_rise)
                begin
                    shreg   <= {sio_data_in, shreg[7:1]};
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7)
                    begin
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                end
            end
        end
    end

    assign sio_en      = busy;              // Timer runs only for a byte in flight.
    assign sio_data_oe = busy && !rd_mode;
    assign rd_data     = shreg;

endmodule

`default_nettype wire

//--- hw/tm1638_sequencer.sv
`default_nettype none

module tm1638_sequencer
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  tm1638_pkg::panel_frame_t frame,
    output logic                     sio_stb,
    output logic                     start,
    output tm1638_pkg::shift_req_t   req,
    input  logic                     done,
    input  logic [7:0]               rd_data,
    output tm1638_pkg::panel_keys_t  keys
);

    tm1638_pkg::tm_state_e    state;
    tm1638_pkg::tm_cmd_e      cmd_byte;
    tm1638_pkg::panel_frame_t snap;
    tm1638_pkg::panel_keys_t  key_buf;
    logic [1:0]               cmd_idx;
    logic [4:0]               byte_idx;    // Data bytes issued in this command.
    logic [4:0]               byte_total;
    logic [1:0]               key_idx;
    logic [7:0]               data_byte;

    always_comb
    begin
        case (cmd_idx)
            2'd0:    cmd_byte = tm1638_pkg::CMD_WRITE_AUTO;
            2'd1:    cmd_byte = tm1638_pkg::CMD_ADDR0;
            2'd2:    cmd_byte = tm1638_pkg::CMD_DISPLAY_ON;
            default: cmd_byte = tm1638_pkg::CMD_READ_KEYS;
        endcase
    end

    // Only the address and key commands carry data bytes.
    assign byte_total = (cmd_idx == 2'd1) ? 5'(2 * tm1638_pkg::DIGITS)
                      : (cmd_idx == 2'd3) ? 5'(tm1638_pkg::KEY_BYTES) : 5'd0;

    // Even bytes are segments, odd bytes light the LED of the same digit.
    assign data_byte = byte_idx[0] ? {7'd0, snap.leds[byte_idx[3:1]]}
                                   : snap.segments[byte_idx[3:1]];
    assign key_idx   = byte_idx[1:0] - 2'd1;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= tm1638_pkg::ST_SNAP;
            cmd_idx  <= '0;
            byte_idx <= '0;
            sio_stb  <= 1'b1;
            start    <= 1'b0;
            key_buf  <= '0;
            keys     <= '0;
        end
        else
        begin
            start <= 1'b0;
            case (state)
                tm1638_pkg::ST_SNAP:
                begin
                    snap    <= frame;  // Frame is frozen for the whole refresh.
                    cmd_idx <= '0;
                    state   <= tm1638_pkg::ST_CMD;
                end
                tm1638_pkg::ST_CMD:
                begin
                    sio_stb  <= 1'b0;
                    start    <= 1'b1;
                    req.data <= cmd_byte;
                    req.read <= 1'b0;
                    byte_idx <= '0;
                    state    <= tm1638_pkg::ST_WAIT;
                end
                tm1638_pkg::ST_DATA:
                begin
                    start    <= 1'b1;
                    req.data <= data_byte;
                    req.read <= (cmd_idx == 2'd3);
                    byte_idx <= byte_idx + 1'b1;
                    state    <= tm1638_pkg::ST_WAIT;
                end
                tm1638_pkg::ST_WAIT:
                    if (done)
                    begin
                        if (req.read)
                        begin
                            key_buf[{key_idx, 1'b0}] <= rd_data[0];
                            key_buf[{key_idx, 1'b1}] <= rd_data[4];
                        end
                        state <= (byte_idx == byte_total) ? tm1638_pkg::ST_END
                                                          : tm1638_pkg::ST_DATA;
                    end
                tm1638_pkg::ST_END:
                begin
                    sio_stb <= 1'b1;
                    if (cmd_idx == 2'd3)
                    begin
                        keys  <= key_buf;
                        state <= tm1638_pkg::ST_SNAP;  // Next refresh right away.
                    end
                    else
                    begin
                        cmd_idx <= cmd_idx + 1'b1;
                        state   <= tm1638_pkg::ST_CMD;
                    end
                end
                default: state <= tm1638_pkg::ST_SNAP;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/level_display.sv
`default_nettype none

module level_display
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  board_pkg::sample_t       sample,
    input  tm1638_pkg::panel_keys_t  keys,
    output tm1638_pkg::panel_frame_t frame
);

    logic [board_pkg::SAMPLE_W:0] ext;
    logic [board_pkg::SAMPLE_W:0] mag;
    logic [7:0]                   level;
    logic                         hold;

    function automatic logic [7:0] hex_font(input logic [3:0] nib);
        case (nib)
            4'h0: return 8'h3F;
            4'h1: return 8'h06;
            4'h2: return 8'h5B;
            4'h3: return 8'h4F;
            4'h4: return 8'h66;
            4'h5: return 8'h6D;
            4'h6: return 8'h7D;
            4'h7: return 8'h07;
            4'h8: return 8'h7F;
            4'h9: return 8'h6F;
            4'hA: return 8'h77;
            4'hB: return 8'h7C;
            4'hC: return 8'h39;
            4'hD: return 8'h5E;
            4'hE: return 8'h79;
            default: return 8'h71;
        endcase
    endfunction

    assign hold = keys[0];

    // One extra bit so that the most negative sample has a magnitude.
    assign ext = {sample.value[board_pkg::SAMPLE_W - 1], sample.value};
    assign mag = ext[board_pkg::SAMPLE_W] ? -ext : ext;

    always_comb
    begin
        for (int i = 0; i < 8; i++)
            level[i] = (mag >> (15 + i)) != '0;  // Bar of 2**15 up to 2**22.
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            frame <= '0;
        else
        begin
            frame.segments[6] <= hex_font(keys[3:0]);
            frame.segments[7] <= hex_font(keys[7:4]);
            if (sample.valid && !hold)
            begin
                for (int d = 0; d < board_pkg::SAMPLE_W / 4; d++)
                    frame.segments[d] <= hex_font(sample.value[4 * d +: 4]);
                frame.leds <= level;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/board_specific_top.sv
`default_nettype none

module board_specific_top
(
    input  logic clk,
    input  logic rst_n,

    output logic mic_sck,
    output logic mic_ws,
    output logic mic_lr,
    input  logic mic_sd,

    output logic sio_clk,
    output logic sio_stb,
    output logic sio_data_out,
    output logic sio_data_oe,
    input  logic sio_data_in
);

    logic                     sck_rise;
    logic                     sck_fall;
    logic [4:0]               sck_fall_cnt;
    logic                     sio_en;
    logic                     sio_rise;
    logic                     sio_fall;
    logic                     shift_start;
    logic                     shift_done;
    logic [7:0]               shift_rd_data;
    tm1638_pkg::shift_req_t   shift_req;
    board_pkg::sample_t       sample;
    tm1638_pkg::panel_frame_t frame;
    tm1638_pkg::panel_keys_t  keys;

    assign mic_lr = 1'b0;  // Left channel.

    // With the 100 MHz board clock (board_pkg::CLK_MHZ) both serial clocks
    // run at 3.125 MHz.
    serial_clk_timer
    #(
        .half_cycles ( board_pkg::SCK_HALF_CYCLES )
    )
    i_sck_timer
    (
        .clk    ( clk      ),
        .rst_n  ( rst_n    ),
        .enable ( 1'b1     ),
        .level  ( mic_sck  ),
        .rise   ( sck_rise ),
        .fall   ( sck_fall )
    );

    // Word select, 32 sck periods per channel.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sck_fall_cnt <= '0;
            mic_ws       <= 1'b0;
        end
        else if (sck_fall)
        begin
            sck_fall_cnt <= sck_fall_cnt + 1'b1;
            if (sck_fall_cnt == 5'd31)
                mic_ws <= ~mic_ws;
        end
    end

    i2s_mic_receiver i_mic
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .sck_rise ( sck_rise ),
        .ws       ( mic_ws   ),
        .sd       ( mic_sd   ),
        .sample   ( sample   )
    );

    level_display i_lab
    (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .sample ( sample ),
        .keys   ( keys   ),
        .frame  ( frame  )
    );

    tm1638_sequencer i_sequencer
    (
        .clk     ( clk           ),
        .rst_n   ( rst_n         ),
        .frame   ( frame         ),
        .sio_stb ( sio_stb       ),
        .start   ( shift_start   ),
        .req     ( shift_req     ),
        .done    ( shift_done    ),
        .rd_data ( shift_rd_data ),
        .keys    ( keys          )
    );

    tm1638_shifter i_shifter
    (
        .clk          ( clk           ),
        .rst_n        ( rst_n         ),
        .start        ( shift_start   ),
        .req          ( shift_req     ),
        .sio_rise     ( sio_rise      ),
        .sio_fall     ( sio_fall      ),
        .sio_en       ( sio_en        ),
        .sio_data_out ( sio_data_out  ),
        .sio_data_oe  ( sio_data_oe   ),
        .sio_data_in  ( sio_data_in   ),
        .done         ( shift_done    ),
        .rd_data      ( shift_rd_data )
    );

    serial_clk_timer
    #(
        .half_cycles ( board_pkg::SIO_HALF_CYCLES )
    )
    i_sio_timer
    (
        .clk    ( clk      ),
        .rst_n  ( rst_n    ),
        .enable ( sio_en   ),
        .level  ( sio_clk  ),
        .rise   ( sio_rise ),
        .fall   ( sio_fall )
    );

endmodule

`default_nettype wire

//--- bench/tb_board_specific_top.sv
`default_nettype none

module tb_board_specific_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES   = 16;
    localparam int WORD_CYCLES    = 64 * 2 * board_pkg::SCK_HALF_CYCLES;  // One I2S frame.
    localparam int REFRESH_CYCLES = 8000;  // Upper bound for one panel refresh.

    // Standard hex font with segment a in bit 0.
    localparam logic [7:0] FONT [16] = '{
        8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07,
        8'h7F, 8'h6F, 8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71
    };
    localparam logic [7:0] EXP_CMDS [4] = '{
        tm1638_pkg::CMD_WRITE_AUTO, tm1638_pkg::CMD_ADDR0,
        tm1638_pkg::CMD_DISPLAY_ON, tm1638_pkg::CMD_READ_KEYS
    };
    localparam int EXP_COUNTS [4] = '{0, 2 * tm1638_pkg::DIGITS, 0, tm1638_pkg::KEY_BYTES};

    logic clk;
    logic rst_n       = 1'b0;
    logic mic_sck;
    logic mic_ws;
    logic mic_lr;
    logic mic_sd      = 1'b0;
    logic sio_clk;
    logic sio_stb;
    logic sio_data_out;
    logic sio_data_oe;
    logic sio_data_in = 1'b0;

    logic [31:0]             lcg_state = 32'haa8d;
    logic [23:0]             cur_sample;
    tm1638_pkg::panel_keys_t exp_keys;

    board_specific_top board_specific_top_inst
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .mic_sck      ( mic_sck      ),
        .mic_ws       ( mic_ws       ),
        .mic_lr       ( mic_lr       ),
        .mic_sd       ( mic_sd       ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data_out ( sio_data_out ),
        .sio_data_oe  ( sio_data_oe  ),
        .sio_data_in  ( sio_data_in  )
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Microphone model that sends mic_value in every left word.
    logic [23:0] mic_value;
    logic [23:0] mic_word;
    int          mic_bits;
    int          word_cnt;
    logic        mic_ws_q;
    logic        mic_sck_q;

    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            mic_ws_q  <= 1'b0;
            mic_sck_q <= 1'b0;
            mic_bits  <= 0;
            word_cnt  <= 0;
            mic_sd    <= 1'b0;
        end
        else
        begin
            mic_ws_q  <= mic_ws;
            mic_sck_q <= mic_sck;
            if (mic_ws_q && !mic_ws)
            begin
                mic_word <= mic_value;  // The delay slot comes first.
                mic_bits <= 24;
            end
            else if (mic_sck_q && !mic_sck && mic_bits > 0)
            begin
                mic_sd   <= mic_word[mic_bits - 1];  // MSB first on the falling sck edge.
                mic_bits <= mic_bits - 1;
                if (mic_bits == 1)
                    word_cnt <= word_cnt + 1;
            end
        end
    end

    // Panel model that records a refresh and answers the key scan.
    logic [7:0]               key_bytes [4];
    logic                     stb_q;
    logic                     sclk_q;
    logic                     reading;
    int                       bit_cnt;
    int                       byte_cnt;
    int                       cmd_cnt;
    int                       oe_errs;
    int                       led_errs;
    logic [7:0]               shreg;
    logic [7:0]               cmd_now;
    logic [7:0]               cmds [8];
    int                       counts [8];
    logic [7:0]               disp [16];
    tm1638_pkg::panel_frame_t frame_tmp;

    int                       refresh_cnt;
    int                       last_cmd_cnt;
    logic [7:0]               last_cmds [4];
    int                       last_counts [4];
    int                       last_oe_errs;
    int                       last_led_errs;
    tm1638_pkg::panel_frame_t last_frame;

    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            stb_q       = 1'b1;
            sclk_q      = 1'b1;
            bit_cnt     = 0;
            byte_cnt    = 0;
            cmd_cnt     = 0;
            oe_errs     = 0;
            led_errs    = 0;
            cmd_now     = 8'h00;
            refresh_cnt <= 0;
            last_frame  <= '0;
            sio_data_in <= 1'b0;
        end
        else
        begin
            if (stb_q && !sio_stb)
            begin
                bit_cnt  = 0;
                byte_cnt = 0;
            end
            reading = (byte_cnt > 0) && (cmd_now == tm1638_pkg::CMD_READ_KEYS);
            if (!sio_stb && sclk_q && !sio_clk && reading && byte_cnt <= 4)
                sio_data_in <= key_bytes[byte_cnt - 1][bit_cnt];
            if (!sio_stb && !sclk_q && sio_clk)
            begin
                if (sio_data_oe == reading)
                    oe_errs = oe_errs + 1;
                shreg   = {sio_data_out, shreg[7:1]};  // LSB arrives first.
                bit_cnt = bit_cnt + 1;
                if (bit_cnt == 8)
                begin
                    bit_cnt = 0;
                    if (byte_cnt == 0)
                        cmd_now = shreg;
                    else if (cmd_now == tm1638_pkg::CMD_ADDR0 && byte_cnt <= 16)
                        disp[byte_cnt - 1] = shreg;
                    byte_cnt = byte_cnt + 1;
                end
            end
            if (!stb_q && sio_stb)
            begin
                if (cmd_cnt < 8)
                begin
                    cmds[cmd_cnt]   = cmd_now;
                    counts[cmd_cnt] = byte_cnt - 1;
                end
                cmd_cnt = cmd_cnt + 1;
                if (cmd_now == tm1638_pkg::CMD_READ_KEYS)
                begin
                    for (int d = 0; d < tm1638_pkg::DIGITS; d++)
                    begin
                        frame_tmp.segments[d] = disp[2 * d];
                        frame_tmp.leds[d]     = disp[2 * d + 1][0];
                        if (disp[2 * d + 1][7:1] != 7'd0)
                            led_errs = led_errs + 1;
                    end
                    for (int i = 0; i < 4; i++)
                    begin
                        last_cmds[i]   <= cmds[i];
                        last_counts[i] <= counts[i];
                    end
                    last_cmd_cnt  <= cmd_cnt;
                    last_oe_errs  <= oe_errs;
                    last_led_errs <= led_errs;
                    last_frame    <= frame_tmp;
                    refresh_cnt   <= refresh_cnt + 1;
                    cmd_cnt  = 0;
                    oe_errs  = 0;
                    led_errs = 0;
                end
            end
            stb_q  = sio_stb;
            sclk_q = sio_clk;
        end
    end

    function automatic logic [23:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:8];
    endfunction

    // LED i is lit when the magnitude reaches 2**(15+i).
    function automatic logic [7:0] expected_leds(input logic [23:0] v);
        longint     mag;
        logic [7:0] leds;
        mag  = longint'($signed(v));
        leds = 8'h00;
        if (mag < 0)
            mag = -mag;
        for (int i = 0; i < 8; i++)
            if (mag >= (longint'(1) << (15 + i)))
                leds[i] = 1'b1;
        return leds;
    endfunction

    function automatic tm1638_pkg::panel_frame_t expected_frame(
        input logic [23:0] v,
        input tm1638_pkg::panel_keys_t k
    );
        tm1638_pkg::panel_frame_t f;
        for (int d = 0; d < 6; d++)
            f.segments[d] = FONT[v[4 * d +: 4]];
        f.segments[6] = FONT[k[3:0]];
        f.segments[7] = FONT[k[7:4]];
        f.leds        = expected_leds(v);
        return f;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_run($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
            stop_run($sformatf("ERR %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            stop_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_level(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            stop_run($sformatf("ERR %s: expected leds %b, actual leds %b", name, exp, act));
    endtask

    task automatic check_frame(
        input string name,
        input tm1638_pkg::panel_frame_t exp,
        input tm1638_pkg::panel_frame_t act
    );
        if (act !== exp)
            stop_run($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic wait_refreshes(input int n);
        int target;
        int cycles;
        target = refresh_cnt + n;
        cycles = 0;
        while (refresh_cnt < target)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > n * REFRESH_CYCLES)
                stop_run("Timeout: the panel refresh did not complete");
        end
    endtask

    task automatic wait_words(input int n);
        int target;
        int cycles;
        target = word_cnt + n;
        cycles = 0;
        while (word_cnt < target)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > (n + 1) * WORD_CYCLES)
                stop_run("Timeout: the microphone word was not sent");
        end
    endtask

    task automatic wait_ws_change(output int cycles, output int rises);
        logic ws_start;
        logic sck_q;
        ws_start = mic_ws;
        sck_q    = mic_sck;
        cycles   = 0;
        rises    = 0;
        while (mic_ws == ws_start)
        begin
            @(negedge clk);
            cycles++;
            if (!sck_q && mic_sck)
                rises++;
            sck_q = mic_sck;
            if (cycles > WORD_CYCLES)
                stop_run("Timeout: mic_ws did not toggle");
        end
    endtask

    // One full word with the new value and then three refreshes.
    task automatic show_sample(input logic [23:0] v);
        mic_value <= v;
        cur_sample = v;
        wait_words(2);
        wait_refreshes(3);
    endtask

    // Byte b sits in kb[8b+7:8b]. Bit 0 is key 2b, bit 4 is key 2b+1.
    task automatic set_keys(input logic [31:0] kb);
        for (int b = 0; b < 4; b++)
        begin
            key_bytes[b]      <= kb[8 * b +: 8];
            exp_keys[2 * b]     = kb[8 * b];
            exp_keys[2 * b + 1] = kb[8 * b + 4];
        end
    endtask

    task automatic test_reset_state();
        check_bit("reset sio_stb", 1'b1, sio_stb);
        check_bit("reset sio_clk", 1'b1, sio_clk);
        check_bit("reset sio_data_oe", 1'b0, sio_data_oe);
        check_bit("reset mic_sck", 1'b0, mic_sck);
    endtask

    task automatic test_mic_clocks();
        int cycles;
        int rises;
        wait_ws_change(cycles, rises);  // Align to a ws edge.
        wait_ws_change(cycles, rises);
        check_count("mic_clocks sck periods per ws half", 32, rises);
        check_count("mic_clocks clk cycles per ws half", 64 * board_pkg::SCK_HALF_CYCLES, cycles);
        check_bit("mic_clocks mic_lr", 1'b0, mic_lr);
    endtask

    task automatic test_refresh_format();
        wait_refreshes(2);
        check_count("refresh_format commands", 4, last_cmd_cnt);
        for (int i = 0; i < 4; i++)
        begin
            check_byte($sformatf("refresh_format command %0d", i), EXP_CMDS[i], last_cmds[i]);
            check_count($sformatf("refresh_format bytes after command %0d", i),
                        EXP_COUNTS[i], last_counts[i]);
        end
        check_count("refresh_format sio_data_oe errors", 0, last_oe_errs);
        check_count("refresh_format LED byte errors", 0, last_led_errs);
    endtask

    task automatic test_lcg_samples();
        logic [23:0] v;
        for (int i = 0; i < 8; i++)
        begin
            v = lcg_next();
            show_sample(v);
            check_frame($sformatf("lcg_samples #%0d (%h)", i, v),
                        expected_frame(v, exp_keys), last_frame);
        end
    endtask

    task automatic test_levels();
        logic [23:0] vals [5];
        vals = '{24'h000000, 24'h008000, 24'hFF0000, 24'h7FFFFF, 24'h800000};
        for (int i = 0; i < 5; i++)
        begin
            show_sample(vals[i]);
            check_level($sformatf("levels %h", vals[i]), expected_leds(vals[i]), last_frame.leds);
        end
    endtask

    task automatic test_keys_and_hold();
        logic [23:0] held;
        logic [23:0] fresh;
        set_keys(32'h0110_11E2);  // Noise bits around keys 2, 3, 5 and 6.
        wait_refreshes(3);
        check_frame("keys digits", expected_frame(cur_sample, exp_keys), last_frame);

        set_keys(32'h1000_0001);  // Key 0 and key 7.
        wait_refreshes(3);
        check_frame("keys hold pressed", expected_frame(cur_sample, exp_keys), last_frame);
        held  = cur_sample;
        fresh = lcg_next();
        show_sample(fresh);
        check_frame("keys hold frozen", expected_frame(held, exp_keys), last_frame);

        set_keys(32'h0000_0000);
        wait_refreshes(3);
        show_sample(fresh);
        check_frame("keys hold released", expected_frame(fresh, exp_keys), last_frame);
    endtask

    initial
    begin
        mic_value <= 24'h000000;
        cur_sample = 24'h000000;
        set_keys(32'h0000_0000);
        repeat (RESET_CYCLES) @(negedge clk);
        test_reset_state();
        rst_n <= 1'b1;

        test_mic_clocks();
        test_refresh_format();
        test_lcg_samples();
        test_levels();
        test_keys_and_hold();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
hw/board_pkg.sv
hw/tm1638_pkg.sv
hw/serial_clk_timer.sv
hw/i2s_mic_receiver.sv
hw/tm1638_shifter.sv
hw/tm1638_sequencer.sv
hw/level_display.sv
hw/board_specific_top.sv
bench/tb_board_specific_top.sv

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_board_specific_top -f src.f -o tb_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/tb_sim)
sim_status=$?
echo "$sim_out"
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "All checks passed" <<< "$sim_out"; then
    echo "Result: PASS"
    exit 0
fi
echo "Result: FAIL"
exit 1
